/* rtl/addr_decode.sv */
`default_nettype none
`timescale 1ns/1ns

`include "soc_periph_settings.svh"

module addr_decode (
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  req_i,
    input  logic                  we_i,
    input  soc_periph_pkg::addr_t addr_i,
    input  soc_periph_pkg::data_t wdata_i,
    input  soc_periph_pkg::data_t clint_rdata_i,
    input  soc_periph_pkg::data_t plic_rdata_i,
    input  logic                  ext_rvalid_i,
    input  soc_periph_pkg::data_t ext_rdata_i,
    output logic                  clint_req_o,
    output logic                  plic_req_o,
    output logic                  ext_req_o,
    output logic                  we_o,
    output soc_periph_pkg::addr_t offset_o,
    output soc_periph_pkg::data_t wdata_o,
    output logic                  ext_we_o,
    output soc_periph_pkg::addr_t ext_addr_o,
    output soc_periph_pkg::data_t ext_wdata_o,
    output logic                  rvalid_o,
    output soc_periph_pkg::data_t rdata_o
);
    import soc_periph_pkg::*;

    region_e     region;
    addr_t       base;
    resp_state_e state_q;
    resp_state_e state_d;
    logic        rd_req;
    logic        local_plic_q;
    logic        ext_done_q;
    data_t       ext_data_q;

    // Region match on offset, which cannot overflow at the top of the map
    always_comb begin
        if ((addr_i - `SOC_CLINT_BASE) < `SOC_CLINT_LEN) begin
            region = REGION_CLINT;
            base   = `SOC_CLINT_BASE;
        end else if ((addr_i - `SOC_PLIC_BASE) < `SOC_PLIC_LEN) begin
            region = REGION_PLIC;
            base   = `SOC_PLIC_BASE;
        end else if ((addr_i - `SOC_EXT_BASE) < `SOC_EXT_LEN) begin
            region = REGION_EXT;
            base   = `SOC_EXT_BASE;
        end else begin
            region = REGION_NONE;
            base   = '0;
        end
    end

    assign rd_req      = req_i && !we_i;
    assign offset_o    = addr_i - base;
    assign we_o        = we_i;
    assign wdata_o     = wdata_i;
    assign clint_req_o = req_i && (region == REGION_CLINT);
    assign plic_req_o  = req_i && (region == REGION_PLIC);
    assign ext_req_o   = req_i && (region == REGION_EXT);
    assign ext_we_o    = we_i;
    assign ext_addr_o  = offset_o;
    assign ext_wdata_o = wdata_i;

    // ------------------------------------------------------------------------
    // Response tracker
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            RESP_LOCAL, RESP_ERR: state_d = RESP_IDLE;
            RESP_EXT: begin
                if (ext_rvalid_i) begin
                    state_d = RESP_IDLE;
                end
            end
            default: state_d = state_q;
        endcase
        if (rd_req) begin
            case (region)
                REGION_CLINT, REGION_PLIC: state_d = RESP_LOCAL;
                REGION_EXT:                state_d = RESP_EXT;
                default:                   state_d = RESP_ERR;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            state_q      <= RESP_IDLE;
            local_plic_q <= 1'b0;
            ext_done_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            ext_done_q <= (state_q == RESP_EXT) && ext_rvalid_i;
            if (rd_req) begin
                local_plic_q <= (region == REGION_PLIC);
            end
        end
    end

    // External reply is returned one cycle after it arrives
    always_ff @(posedge clk_i) begin
        if ((state_q == RESP_EXT) && ext_rvalid_i) begin
            ext_data_q <= ext_rdata_i;
        end
    end

    assign rvalid_o = (state_q == RESP_LOCAL) || (state_q == RESP_ERR) || ext_done_q;

    always_comb begin
        if (ext_done_q) begin
            rdata_o = ext_data_q;
        end else if (state_q == RESP_ERR) begin
            rdata_o = `SOC_DECERR_DATA;
        end else if (state_q == RESP_LOCAL) begin
            rdata_o = local_plic_q ? plic_rdata_i : clint_rdata_i;
        end else begin
            rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/clint.sv */
`default_nettype none
`timescale 1ns/1ns

module clint (
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  req_i,
    input  logic                  we_i,
    input  soc_periph_pkg::addr_t offset_i,
    input  soc_periph_pkg::data_t wdata_i,
    output soc_periph_pkg::data_t rdata_o,
    output logic                  timer_irq_o,
    output logic                  ipi_o
);
    import soc_periph_pkg::*;

    localparam addr_t MSIP_OFF        = 32'h0000_0000;
    localparam addr_t MTIMECMP_LO_OFF = 32'h0000_4000;
    localparam addr_t MTIMECMP_HI_OFF = 32'h0000_4004;
    localparam addr_t MTIME_LO_OFF    = 32'h0000_BFF8;
    localparam addr_t MTIME_HI_OFF    = 32'h0000_BFFC;

    logic   wr;
    logic   rd;
    logic   rtc_q;
    logic   msip_q;
    logic   timer_irq_q;
    mtime_t mtime_q;
    mtime_t mtimecmp_q;
    data_t  rdata_d;
    data_t  rdata_q;

    assign wr = req_i && we_i;
    assign rd = req_i && !we_i;

    // ------------------------------------------------------------------------
    // Real-time tick and timer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q       <= 1'b0;
            msip_q      <= 1'b0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_q <= 1'b0;
        end else begin
            // Half clock rate
            rtc_q       <= ~rtc_q;
            timer_irq_q <= (mtime_q >= mtimecmp_q);

            if (wr && (offset_i == MSIP_OFF)) begin
                msip_q <= wdata_i[0];
            end

            if (wr && (offset_i == MTIMECMP_LO_OFF)) begin
                mtimecmp_q <= {mtimecmp_q[63:32], wdata_i};
            end else if (wr && (offset_i == MTIMECMP_HI_OFF)) begin
                mtimecmp_q <= {wdata_i, mtimecmp_q[31:0]};
            end

            // Software write wins over the tick
            if (wr && (offset_i == MTIME_LO_OFF)) begin
                mtime_q <= {mtime_q[63:32], wdata_i};
            end else if (wr && (offset_i == MTIME_HI_OFF)) begin
                mtime_q <= {wdata_i, mtime_q[31:0]};
            end else if (rtc_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
        end
    end

    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = msip_q;

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------
    always_comb begin
        case (offset_i)
            MSIP_OFF:        rdata_d = {31'd0, msip_q};
            MTIMECMP_LO_OFF: rdata_d = mtimecmp_q[31:0];
            MTIMECMP_HI_OFF: rdata_d = mtimecmp_q[63:32];
            MTIME_LO_OFF:    rdata_d = mtime_q[31:0];
            MTIME_HI_OFF:    rdata_d = mtime_q[63:32];
            default:         rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* rtl/plic.sv */
`default_nettype none
`timescale 1ns/1ns

`include "soc_periph_settings.svh"

module plic (
    input  logic                     clk_i,
    input  logic                     ndmreset_n,
    input  logic                     req_i,
    input  logic                     we_i,
    input  soc_periph_pkg::addr_t    offset_i,
    input  soc_periph_pkg::data_t    wdata_i,
    input  soc_periph_pkg::src_vec_t irq_sources_i,
    output soc_periph_pkg::data_t    rdata_o,
    output soc_periph_pkg::tgt_vec_t eip_o
);
    import soc_periph_pkg::*;

    localparam int    NSRC        = `SOC_NUM_SOURCES;
    localparam int    NTGT        = `SOC_NUM_TARGETS;
    localparam addr_t PENDING_OFF = 32'h0000_1000;
    localparam addr_t ENABLE_BASE = 32'h0000_2000;
    localparam addr_t ENABLE_STEP = 32'h0000_0080;
    localparam addr_t TARGET_BASE = 32'h0020_0000;
    localparam addr_t TARGET_STEP = 32'h0000_1000;

    logic     wr;
    logic     rd;
    prio_t    prio_q [NSRC];
    src_vec_t pending_q;
    src_vec_t in_service_q;
    src_vec_t enable_q [NTGT];
    prio_t    threshold_q [NTGT];
    src_id_t  best_id [NTGT];
    prio_t    best_prio [NTGT];
    src_vec_t claim_mask;
    src_vec_t complete_mask;
    data_t    rdata_d;
    data_t    rdata_q;

    assign wr = req_i && we_i;
    assign rd = req_i && !we_i;

    // ------------------------------------------------------------------------
    // Per-target arbitration
    // ------------------------------------------------------------------------
    // Strict compare keeps the lowest id on equal priority
    always_comb begin
        for (int t = 0; t < NTGT; t++) begin
            best_id[t]   = '0;
            best_prio[t] = threshold_q[t];
            for (int s = 0; s < NSRC; s++) begin
                if (pending_q[s] && enable_q[t][s] && (prio_q[s] > best_prio[t])) begin
                    best_id[t]   = src_id_t'(s + 1);
                    best_prio[t] = prio_q[s];
                end
            end
            eip_o[t] = (best_id[t] != '0);
        end
    end

    // Claim on read, complete on write of the id
    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        for (int t = 0; t < NTGT; t++) begin
            if (offset_i == TARGET_BASE + TARGET_STEP * addr_t'(t) + 32'd4) begin
                for (int s = 0; s < NSRC; s++) begin
                    if (rd && (best_id[t] == src_id_t'(s + 1))) begin
                        claim_mask[s] = 1'b1;
                    end
                    if (wr && (wdata_i == data_t'(s + 1))) begin
                        complete_mask[s] = 1'b1;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            pending_q    <= '0;
            in_service_q <= '0;
            for (int s = 0; s < NSRC; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NTGT; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
        end else begin
            // Level gateway, blocked while the source is in service
            pending_q    <= (pending_q | (irq_sources_i & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;

            for (int s = 0; s < NSRC; s++) begin
                if (wr && (offset_i == addr_t'(4 * (s + 1)))) begin
                    prio_q[s] <= wdata_i[`SOC_PRIO_BITS-1:0];
                end
            end
            for (int t = 0; t < NTGT; t++) begin
                if (wr && (offset_i == ENABLE_BASE + ENABLE_STEP * addr_t'(t))) begin
                    enable_q[t] <= wdata_i[NSRC-1:0];
                end
                if (wr && (offset_i == TARGET_BASE + TARGET_STEP * addr_t'(t))) begin
                    threshold_q[t] <= wdata_i[`SOC_PRIO_BITS-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------
    always_comb begin
        rdata_d = '0;
        if (offset_i == PENDING_OFF) begin
            rdata_d = data_t'(pending_q);
        end
        for (int s = 0; s < NSRC; s++) begin
            if (offset_i == addr_t'(4 * (s + 1))) begin
                rdata_d = data_t'(prio_q[s]);
            end
        end
        for (int t = 0; t < NTGT; t++) begin
            if (offset_i == ENABLE_BASE + ENABLE_STEP * addr_t'(t)) begin
                rdata_d = data_t'(enable_q[t]);
            end
            if (offset_i == TARGET_BASE + TARGET_STEP * addr_t'(t)) begin
                rdata_d = data_t'(threshold_q[t]);
            end
            if (offset_i == TARGET_BASE + TARGET_STEP * addr_t'(t) + 32'd4) begin
                rdata_d = data_t'(best_id[t]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* rtl/soc_periph_pkg.sv */
`default_nettype none

`include "soc_periph_settings.svh"

package soc_periph_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [63:0] mtime_t;

    typedef logic [`SOC_PRIO_BITS-1:0] prio_t;
    typedef logic [$clog2(`SOC_NUM_SOURCES + 1)-1:0] src_id_t;

    // Bit 0 stands for source id 1
    typedef logic [`SOC_NUM_SOURCES-1:0] src_vec_t;
    typedef logic [`SOC_NUM_TARGETS-1:0] tgt_vec_t;

    typedef enum logic [1:0] {
        REGION_CLINT,
        REGION_PLIC,
        REGION_EXT,
        REGION_NONE
    } region_e;

    // Where an outstanding read gets its answer
    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_LOCAL,
        RESP_EXT,
        RESP_ERR
    } resp_state_e;

endpackage

`default_nettype wire

/* rtl/soc_periph_settings.svh */
`ifndef SOC_PERIPH_SETTINGS_SVH
`define SOC_PERIPH_SETTINGS_SVH

// ----------------------------------------------------------------------------
// Memory map
// ----------------------------------------------------------------------------
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_LEN 32'h0000_C000

`define SOC_PLIC_BASE 32'h0C00_0000
`define SOC_PLIC_LEN 32'h0400_0000

`define SOC_EXT_BASE 32'h8000_0000
`define SOC_EXT_LEN 32'h4000_0000

// ----------------------------------------------------------------------------
// Interrupt controller sizing
// ----------------------------------------------------------------------------
// Source ids 1..N, id 0 means no interrupt
`define SOC_NUM_SOURCES 8
`define SOC_NUM_TARGETS 2
`define SOC_PRIO_BITS 3

// Read data for an unmapped address
`define SOC_DECERR_DATA 32'hDEAD_BEEF

`endif

/* rtl/soc_periph_top.sv */
`default_nettype none
`timescale 1ns/1ns

module soc_periph_top (
    input  logic                     clk_i,
    input  logic                     ndmreset_n,
    input  logic                     req_i,
    input  logic                     we_i,
    input  soc_periph_pkg::addr_t    addr_i,
    input  soc_periph_pkg::data_t    wdata_i,
    output logic                     rvalid_o,
    output soc_periph_pkg::data_t    rdata_o,
    output logic                     ext_req_o,
    output logic                     ext_we_o,
    output soc_periph_pkg::addr_t    ext_addr_o,
    output soc_periph_pkg::data_t    ext_wdata_o,
    input  logic                     ext_rvalid_i,
    input  soc_periph_pkg::data_t    ext_rdata_i,
    input  soc_periph_pkg::src_vec_t irq_sources_i,
    output logic                     timer_irq_o,
    output logic                     ipi_o,
    output soc_periph_pkg::tgt_vec_t eip_o
);
    import soc_periph_pkg::*;

    logic  clint_req;
    logic  plic_req;
    logic  dec_we;
    addr_t dec_offset;
    data_t dec_wdata;
    data_t clint_rdata;
    data_t plic_rdata;

    // ------------------------------------------------------------------------
    // Address decoder
    // ------------------------------------------------------------------------
    addr_decode i_addr_decode (
        .clk_i         ( clk_i        ),
        .ndmreset_n    ( ndmreset_n   ),
        .req_i         ( req_i        ),
        .we_i          ( we_i         ),
        .addr_i        ( addr_i       ),
        .wdata_i       ( wdata_i      ),
        .clint_rdata_i ( clint_rdata  ),
        .plic_rdata_i  ( plic_rdata   ),
        .ext_rvalid_i  ( ext_rvalid_i ),
        .ext_rdata_i   ( ext_rdata_i  ),
        .clint_req_o   ( clint_req    ),
        .plic_req_o    ( plic_req     ),
        .ext_req_o     ( ext_req_o    ),
        .we_o          ( dec_we       ),
        .offset_o      ( dec_offset   ),
        .wdata_o       ( dec_wdata    ),
        .ext_we_o      ( ext_we_o     ),
        .ext_addr_o    ( ext_addr_o   ),
        .ext_wdata_o   ( ext_wdata_o  ),
        .rvalid_o      ( rvalid_o     ),
        .rdata_o       ( rdata_o      )
    );

    // ------------------------------------------------------------------------
    // Timer and software interrupt
    // ------------------------------------------------------------------------
    clint i_clint (
        .clk_i       ( clk_i       ),
        .ndmreset_n  ( ndmreset_n  ),
        .req_i       ( clint_req   ),
        .we_i        ( dec_we      ),
        .offset_i    ( dec_offset  ),
        .wdata_i     ( dec_wdata   ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

    // ------------------------------------------------------------------------
    // External interrupts, all sources level
    // ------------------------------------------------------------------------
    plic i_plic (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .req_i         ( plic_req      ),
        .we_i          ( dec_we        ),
        .offset_i      ( dec_offset    ),
        .wdata_i       ( dec_wdata     ),
        .irq_sources_i ( irq_sources_i ),
        .rdata_o       ( plic_rdata    ),
        .eip_o         ( eip_o         )
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module soc_periph_tb \
    -f soc_periph.f \
    --Mdir obj_dir -o soc_periph_sim

./obj_dir/soc_periph_sim | tee "$LOG"

if grep -q "All checks passed" "$LOG"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED, see $LOG"
    exit 1
fi

/* soc_periph.f */
+incdir+rtl
rtl/soc_periph_pkg.sv
rtl/addr_decode.sv
rtl/clint.sv
rtl/plic.sv
rtl/soc_periph_top.sv
tests/soc_periph_chk.sv
tests/soc_periph_tb.sv

/* tests/soc_periph_chk.sv */
`default_nettype none
`timescale 1ns/1ns

module soc_periph_chk (
    input logic                     clk_i,
    input logic                     ndmreset_n,
    input logic                     req_i,
    input logic                     we_i,
    input logic                     rvalid_i,
    input logic                     ext_req_i,
    input logic                     timer_irq_i,
    input logic                     ipi_i,
    input soc_periph_pkg::tgt_vec_t eip_i
);

    logic rd_pending_q;

    // Read issued and not yet answered
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rd_pending_q <= 1'b0;
        end else if (req_i && !we_i) begin
            rd_pending_q <= 1'b1;
        end else if (rvalid_i) begin
            rd_pending_q <= 1'b0;
        end
    end

    rvalid_needs_read: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        rvalid_i |-> rd_pending_q)
        else $error("rvalid_o without an outstanding read");

    ext_req_needs_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        ext_req_i |-> req_i)
        else $error("ext_req_o without req_i");

    irq_low_in_reset: assert property (@(posedge clk_i)
        !ndmreset_n |-> (!timer_irq_i && !ipi_i && (eip_i == '0)))
        else $error("interrupt output high during reset");

endmodule

bind soc_periph_top soc_periph_chk i_chk (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .rvalid_i    ( rvalid_o    ),
    .ext_req_i   ( ext_req_o   ),
    .timer_irq_i ( timer_irq_o ),
    .ipi_i       ( ipi_o       ),
    .eip_i       ( eip_o       )
);

`default_nettype wire

/* tests/soc_periph_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "soc_periph_settings.svh"

module soc_periph_tb;
    import soc_periph_pkg::*;

    // Directed sequence needs well under a thousand cycles
    localparam int TIMEOUT_CYCLES = 20000;

    localparam addr_t MSIP_ADDR        = `SOC_CLINT_BASE;
    localparam addr_t MTIMECMP_LO_ADDR = `SOC_CLINT_BASE + 32'h0000_4000;
    localparam addr_t MTIMECMP_HI_ADDR = `SOC_CLINT_BASE + 32'h0000_4004;
    localparam addr_t MTIME_LO_ADDR    = `SOC_CLINT_BASE + 32'h0000_BFF8;
    localparam addr_t MTIME_HI_ADDR    = `SOC_CLINT_BASE + 32'h0000_BFFC;
    localparam addr_t PENDING_ADDR     = `SOC_PLIC_BASE + 32'h0000_1000;
    localparam addr_t ENABLE0_ADDR     = `SOC_PLIC_BASE + 32'h0000_2000;
    localparam addr_t THRESH0_ADDR     = `SOC_PLIC_BASE + 32'h0020_0000;
    localparam addr_t CLAIM0_ADDR      = `SOC_PLIC_BASE + 32'h0020_0004;
    localparam addr_t UNMAPPED_ADDR    = 32'h4000_0000;

    logic     clk_i;
    logic     ndmreset_n;
    logic     req_i;
    logic     we_i;
    addr_t    addr_i;
    data_t    wdata_i;
    logic     rvalid_o;
    data_t    rdata_o;
    logic     ext_req_o;
    logic     ext_we_o;
    addr_t    ext_addr_o;
    data_t    ext_wdata_o;
    logic     ext_rvalid_i;
    data_t    ext_rdata_i;
    src_vec_t irq_sources_i;
    logic     timer_irq_o;
    logic     ipi_o;
    tgt_vec_t eip_o;

    logic [31:0] lcg_state;
    int          cycle_count;
    int          error_count;
    data_t       ext_mem [addr_t];
    addr_t       ext_last_addr;
    logic        ext_last_we;
    int          ext_access_count;

    soc_periph_top dut (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .req_i         ( req_i         ),
        .we_i          ( we_i          ),
        .addr_i        ( addr_i        ),
        .wdata_i       ( wdata_i       ),
        .rvalid_o      ( rvalid_o      ),
        .rdata_o       ( rdata_o       ),
        .ext_req_o     ( ext_req_o     ),
        .ext_we_o      ( ext_we_o      ),
        .ext_addr_o    ( ext_addr_o    ),
        .ext_wdata_o   ( ext_wdata_o   ),
        .ext_rvalid_i  ( ext_rvalid_i  ),
        .ext_rdata_i   ( ext_rdata_i   ),
        .irq_sources_i ( irq_sources_i ),
        .timer_irq_o   ( timer_irq_o   ),
        .ipi_o         ( ipi_o         ),
        .eip_o         ( eip_o         )
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Unwritten external words read back a pattern of their offset
    function automatic data_t ext_fill(input addr_t offset);
        return offset ^ 32'h5A5A_5A5A;
    endfunction

    function automatic src_vec_t src_bit(input int id);
        return src_vec_t'(1) << (id - 1);
    endfunction

    // ------------------------------------------------------------------------
    // External memory model
    // ------------------------------------------------------------------------
    initial begin : ext_memory_model
        int    delay;
        addr_t offset;
        lcg_state    = 32'h924f;
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            if (ndmreset_n === 1'b1 && ext_req_o === 1'b1) begin
                offset        = ext_addr_o;
                ext_last_addr = offset;
                ext_last_we   = ext_we_o;
                ext_access_count++;
                if (ext_we_o) begin
                    ext_mem[offset] = ext_wdata_o;
                end else begin
                    // Reply 1 to 4 cycles after the request
                    delay = 1 + int'(lcg_next() >> 16) % 4;
                    repeat (delay - 1) @(posedge clk_i);
                    #2;
                    ext_rvalid_i = 1'b1;
                    ext_rdata_i  = ext_mem.exists(offset) ? ext_mem[offset] : ext_fill(offset);
                    @(posedge clk_i);
                    #2;
                    ext_rvalid_i = 1'b0;
                    ext_rdata_i  = '0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        error_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_data(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is 0x%08h, expected 0x%08h", what, actual, expected));
        end
    endtask

    task automatic check_mtime(input mtime_t actual, input mtime_t lo, input mtime_t hi,
                               input string what);
        if ($isunknown(actual) || actual < lo || actual > hi) begin
            report_mismatch($sformatf("%s is %0d, expected %0d to %0d", what, actual, lo, hi));
        end
    endtask

    task automatic check_irq(input tgt_vec_t actual, input tgt_vec_t expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------
    task automatic bus_write(input addr_t addr, input data_t data);
        @(posedge clk_i);
        #2;
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        @(posedge clk_i);
        #2;
        req_i = 1'b0;
        we_i  = 1'b0;
    endtask

    // Latency counts cycles from the request edge to rvalid_o
    task automatic bus_read(input addr_t addr, output data_t data, output int latency);
        @(posedge clk_i);
        #2;
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = addr;
        @(posedge clk_i);
        #2;
        req_i   = 1'b0;
        latency = 1;
        while (rvalid_o !== 1'b1) begin
            @(posedge clk_i);
            #2;
            latency++;
        end
        data = rdata_o;
    endtask

    task automatic read_local(input addr_t addr, input data_t expected, input string what);
        data_t data;
        int    latency;
        bus_read(addr, data, latency);
        check_bit(latency == 1, 1'b1, {what, " answered in one cycle"});
        check_data(data, expected, what);
    endtask

    task automatic read_mtime(output mtime_t value);
        data_t lo;
        data_t hi;
        int    latency;
        bus_read(MTIME_LO_ADDR, lo, latency);
        bus_read(MTIME_HI_ADDR, hi, latency);
        value = {hi, lo};
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_and_ipi();
        check_bit(timer_irq_o, 1'b0, "timer_irq_o after reset");
        check_bit(ipi_o, 1'b0, "ipi_o after reset");
        check_irq(eip_o, '0, "eip_o after reset");
        read_local(MTIMECMP_LO_ADDR, 32'hFFFF_FFFF, "mtimecmp low after reset");
        read_local(MTIMECMP_HI_ADDR, 32'hFFFF_FFFF, "mtimecmp high after reset");
        bus_write(MSIP_ADDR, 32'd1);
        check_bit(ipi_o, 1'b1, "ipi_o after msip set");
        read_local(MSIP_ADDR, 32'd1, "msip readback");
        bus_write(MSIP_ADDR, 32'd0);
        check_bit(ipi_o, 1'b0, "ipi_o after msip clear");
    endtask

    task automatic test_timer();
        mtime_t first;
        mtime_t second;
        mtime_t target;
        int     waited;
        read_mtime(first);
        // Low halves sampled 100 cycles apart
        repeat (96) @(posedge clk_i);
        read_mtime(second);
        check_mtime(second - first, 64'd49, 64'd51, "mtime advance over 100 cycles");

        read_mtime(target);
        target = target + 64'd20;
        bus_write(MTIMECMP_LO_ADDR, target[31:0]);
        bus_write(MTIMECMP_HI_ADDR, target[63:32]);
        check_bit(timer_irq_o, 1'b0, "timer_irq_o before compare match");
        waited = 0;
        while (timer_irq_o !== 1'b1 && waited < 50) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        check_bit(timer_irq_o, 1'b1, "timer_irq_o within 50 cycles");

        bus_write(MTIMECMP_HI_ADDR, 32'hFFFF_FFFF);
        bus_write(MTIMECMP_LO_ADDR, 32'hFFFF_FFFF);
        @(posedge clk_i);
        #2;
        check_bit(timer_irq_o, 1'b0, "timer_irq_o after mtimecmp all ones");
    endtask

    task automatic test_plic_arbitration();
        bus_write(`SOC_PLIC_BASE + 32'd8, 32'd3);
        bus_write(`SOC_PLIC_BASE + 32'd20, 32'd6);
        bus_write(`SOC_PLIC_BASE + 32'd24, 32'd6);
        bus_write(ENABLE0_ADDR, 32'h0000_00FF);
        bus_write(THRESH0_ADDR, 32'd2);
        irq_sources_i = src_bit(2) | src_bit(5) | src_bit(6);
        repeat (2) @(posedge clk_i);
        #2;
        check_irq(eip_o, tgt_vec_t'(1), "eip_o with three sources raised");

        // Highest priority first, lowest id on a tie
        read_local(CLAIM0_ADDR, 32'd5, "first claim");
        read_local(CLAIM0_ADDR, 32'd6, "second claim");
        read_local(CLAIM0_ADDR, 32'd2, "third claim");
        check_irq(eip_o, '0, "eip_o with all sources in service");

        irq_sources_i = '0;
        bus_write(CLAIM0_ADDR, 32'd5);
        bus_write(CLAIM0_ADDR, 32'd6);
        bus_write(CLAIM0_ADDR, 32'd2);
        repeat (2) @(posedge clk_i);
        #2;
        check_irq(eip_o, '0, "eip_o after completion");
        read_local(PENDING_ADDR, 32'd0, "pending after completion");
    endtask

    task automatic test_threshold_pending();
        bus_write(THRESH0_ADDR, 32'd6);
        irq_sources_i = src_bit(2) | src_bit(5);
        repeat (2) @(posedge clk_i);
        #2;
        check_irq(eip_o, '0, "eip_o with priority equal to threshold");
        read_local(PENDING_ADDR, data_t'(src_bit(2) | src_bit(5)), "pending with two sources");
        read_local(CLAIM0_ADDR, 32'd0, "claim with nothing above threshold");
        read_local(PENDING_ADDR, data_t'(src_bit(2) | src_bit(5)), "pending after empty claim");

        bus_write(THRESH0_ADDR, 32'd5);
        check_irq(eip_o, tgt_vec_t'(1), "eip_o with threshold 5");
        read_local(CLAIM0_ADDR, 32'd5, "claim with threshold 5");
        read_local(PENDING_ADDR, data_t'(src_bit(2)), "pending after claim of source 5");
        check_irq(eip_o, '0, "eip_o with only source 2 pending");
        irq_sources_i = '0;
        bus_write(CLAIM0_ADDR, 32'd5);
    endtask

    task automatic test_ext_and_unmapped();
        data_t data;
        int    latency;
        int    count;
        addr_t offset;
        bus_write(`SOC_EXT_BASE + 32'h10, 32'h1234_5678);
        check_data(ext_last_addr, 32'h10, "external write offset");
        check_bit(ext_last_we, 1'b1, "external write enable");
        bus_read(`SOC_EXT_BASE + 32'h10, data, latency);
        check_data(ext_last_addr, 32'h10, "external read offset");
        check_data(data, 32'h1234_5678, "external readback");

        for (int i = 0; i < 6; i++) begin
            offset = 32'h1000_0000 + 32'h44 * addr_t'(i);
            bus_read(`SOC_EXT_BASE + offset, data, latency);
            check_data(ext_last_addr, offset, "external read offset");
            check_data(data, offset ^ 32'h5A5A_5A5A, "external fill word");
            check_bit(latency >= 2 && latency <= 5, 1'b1, "external read latency in 2..5");
        end

        read_local(UNMAPPED_ADDR, `SOC_DECERR_DATA, "unmapped read");
        read_local(32'hC000_0000, `SOC_DECERR_DATA, "read above external window");
        count = ext_access_count;
        bus_write(UNMAPPED_ADDR, 32'hFFFF_0000);
        check_bit(ext_access_count == count, 1'b1, "unmapped write kept off external port");
    endtask

    initial begin
        cycle_count      = 0;
        error_count      = 0;
        ext_access_count = 0;
        ext_last_addr    = '0;
        ext_last_we      = 1'b0;
        ndmreset_n       = 1'b1;
        req_i            = 1'b0;
        we_i             = 1'b0;
        addr_i           = '0;
        wdata_i          = '0;
        irq_sources_i    = '0;
        #1;
        ndmreset_n = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        ndmreset_n = 1'b1;

        test_reset_and_ipi();
        test_timer();
        test_plic_arbitration();
        test_threshold_pending();
        test_ext_and_unmapped();

        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
